//--- sources.f
+incdir+.
isa_pkg.sv
bus_pkg.sv
reg_file.sv
decoder.sv
exec_unit.sv
stage_reg.sv
fetch_unit.sv
wb_master.sv
core_top.sv
tb_core.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_core
FILELIST  := sources.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x -F -e '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)

//--- tb_core.sv
`include "cpu_defs.svh"

module tb_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD = 20;
    localparam logic [31:0] DATA_BASE  = 32'h1c00_1000;
    localparam logic [31:0] DONE_ADDR  = DATA_BASE + 32'h0fc;
    localparam logic [31:0] LOAD_ADDR  = DATA_BASE + 32'h100;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_ADDI,
        OP_LU12I, OP_LD, OP_ST, OP_BEQ, OP_BNE, OP_B
    } op_e;

    // Branch and jump immediates are byte offsets from the branch itself.
    typedef struct packed {
        op_e         op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] imm;
    } instr_t;

    logic               clk = 1'b0;
    logic               rst_n;
    logic [`XLEN-1:0]   wb_dat_r = '0;
    logic               wb_ack = 1'b0;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [`XLEN-1:0]   wb_adr;
    logic [`XLEN-1:0]   wb_dat_w;
    logic [`NBYTE-1:0]  wb_sel;

    logic [31:0] mem [logic [31:0]];
    logic [31:0] ref_mem [logic [31:0]];
    instr_t      prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic        prog_ready = 1'b0;
    integer      seed = 7295;
    int          wait_left = 0;
    logic        in_xfer = 1'b0;
    int          stores_seen = 0;

    logic        rst_q = 1'b0;
    logic        pending_q = 1'b0;
    logic        acked_q = 1'b0;
    logic [31:0] prev_adr;
    logic [31:0] prev_dat;
    logic        prev_we;

    core_top core_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Failure handling

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic value_mismatch(string name, logic [31:0] want, logic [31:0] got);
        $display("error at %0t ns: %s expected %h, actual %h", $time, name, want, got);
        abort_run();
    endtask

    task automatic rule_broken(string what);
        $display("At %0t ns: %s.", $time, what);
        abort_run();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Program image and reference model

    function automatic logic [31:0] fill_word(logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;  // Unwritten words still vary.
    endfunction

    function automatic logic [31:0] read_word(logic [31:0] a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    function automatic logic [31:0] encode(instr_t i);
        case (i.op)
            OP_ADD:   return {17'h00020, i.rk, i.rj, i.rd};
            OP_SUB:   return {17'h00022, i.rk, i.rj, i.rd};
            OP_SLT:   return {17'h00024, i.rk, i.rj, i.rd};
            OP_AND:   return {17'h00029, i.rk, i.rj, i.rd};
            OP_OR:    return {17'h0002a, i.rk, i.rj, i.rd};
            OP_XOR:   return {17'h0002b, i.rk, i.rj, i.rd};
            OP_ADDI:  return {10'h00a, i.imm[11:0], i.rj, i.rd};
            OP_LU12I: return {7'b0001010, i.imm[19:0], i.rd};
            OP_LD:    return {10'h0a2, i.imm[11:0], i.rj, i.rd};
            OP_ST:    return {10'h0a6, i.imm[11:0], i.rj, i.rd};
            OP_BEQ:   return {6'b010110, i.imm[17:2], i.rj, i.rd};
            OP_BNE:   return {6'b010111, i.imm[17:2], i.rj, i.rd};
            default:  return {6'b010100, i.imm[17:2], i.imm[27:18]};
        endcase
    endfunction

    task automatic preload(logic [31:0] addr, logic [31:0] data);
        mem[addr]     = data;
        ref_mem[addr] = data;
    endtask

    task automatic emit(op_e op, int rd, int rj, int rk, int imm);
        instr_t ins;
        ins.op  = op;
        ins.rd  = rd[4:0];
        ins.rj  = rj[4:0];
        ins.rk  = rk[4:0];
        ins.imm = imm;
        preload(`RESET_PC + 32'(4 * prog.size()), encode(ins));
        prog.push_back(ins);
    endtask

    task automatic build_program();
        emit(OP_LU12I, 1, 0, 0, 'h1c001);       // r1 points at the data area.
        emit(OP_ADDI, 2, 0, 0, 'h123);
        emit(OP_ADDI, 3, 2, 0, -5);             // Reads r2 right behind its producer.
        emit(OP_ADD, 4, 2, 3, 0);
        emit(OP_ST, 4, 1, 0, 0);
        emit(OP_SUB, 5, 3, 2, 0);
        emit(OP_ST, 5, 1, 0, 4);
        emit(OP_OR, 6, 4, 5, 0);
        emit(OP_XOR, 7, 2, 3, 0);
        emit(OP_AND, 16, 4, 7, 0);
        emit(OP_SLT, 8, 5, 2, 0);
        emit(OP_SLT, 9, 2, 5, 0);
        emit(OP_ST, 6, 1, 0, 8);
        emit(OP_ST, 7, 1, 0, 12);
        emit(OP_ST, 16, 1, 0, 16);
        emit(OP_ST, 8, 1, 0, 20);
        emit(OP_ST, 9, 1, 0, 24);
        emit(OP_ADDI, 0, 0, 0, 'h55);
        emit(OP_ADD, 11, 0, 2, 0);
        emit(OP_ST, 0, 1, 0, 28);
        emit(OP_ST, 11, 1, 0, 32);
        emit(OP_LD, 12, 1, 0, 'h100);
        emit(OP_ST, 12, 1, 0, 36);
        emit(OP_LD, 13, 1, 0, 4);               // Reads back an earlier store.
        emit(OP_ADDI, 13, 13, 0, 1);
        emit(OP_ST, 13, 1, 0, 40);
        emit(OP_BEQ, 3, 2, 0, 12);
        emit(OP_ST, 2, 1, 0, 44);
        emit(OP_BNE, 3, 2, 0, 12);
        emit(OP_ST, 0, 1, 0, 'h80);
        emit(OP_ST, 0, 1, 0, 'h84);
        emit(OP_BEQ, 0, 9, 0, 12);
        emit(OP_ST, 2, 1, 0, 'h88);
        emit(OP_ST, 2, 1, 0, 'h8c);
        emit(OP_B, 0, 0, 0, 12);
        emit(OP_ST, 2, 1, 0, 'h90);
        emit(OP_ST, 2, 1, 0, 'h94);
        emit(OP_BNE, 0, 0, 0, 8);
        emit(OP_ADDI, 15, 0, 0, 3);
        emit(OP_ADDI, 15, 15, 0, -1);           // Loop body, runs three times.
        emit(OP_ST, 15, 1, 0, 48);
        emit(OP_BNE, 0, 15, 0, -8);
        emit(OP_ADDI, 14, 0, 0, -2048);
        emit(OP_ST, 14, 1, 0, 52);
        emit(OP_ST, 8, 1, 0, 'hfc);
        emit(OP_B, 0, 0, 0, 0);
        preload(LOAD_ADDR, 32'hcafe_f00d);
    endtask

    task automatic run_reference();
        logic [31:0] rf [32];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] a;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] idx;
        instr_t      ins;
        int          steps;
        logic        done;
        logic        wr;
        foreach (rf[i]) rf[i] = '0;
        pc    = `RESET_PC;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 1000) begin
            idx = (pc - `RESET_PC) >> 2;
            if (idx >= 32'(prog.size())) break;
            ins     = prog[idx];
            a       = rf[ins.rj];
            res     = '0;
            wr      = 1'b1;
            next_pc = pc + 32'd4;
            case (ins.op)
                OP_ADD:   res = a + rf[ins.rk];
                OP_SUB:   res = a - rf[ins.rk];
                OP_AND:   res = a & rf[ins.rk];
                OP_OR:    res = a | rf[ins.rk];
                OP_XOR:   res = a ^ rf[ins.rk];
                OP_SLT:   res = ($signed(a) < $signed(rf[ins.rk])) ? 32'd1 : 32'd0;
                OP_ADDI:  res = a + ins.imm;
                OP_LU12I: res = {ins.imm[19:0], 12'h000};
                OP_LD: begin
                    addr = a + ins.imm;
                    res  = ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
                end
                OP_ST: begin
                    wr            = 1'b0;
                    addr          = a + ins.imm;
                    ref_mem[addr] = rf[ins.rd];
                    exp_addr.push_back(addr);
                    exp_data.push_back(rf[ins.rd]);
                    done = (addr == DONE_ADDR);
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (a == rf[ins.rd]) next_pc = pc + ins.imm;
                end
                OP_BNE: begin
                    wr = 1'b0;
                    if (a != rf[ins.rd]) next_pc = pc + ins.imm;
                end
                default: begin
                    wr      = 1'b0;
                    next_pc = pc + ins.imm;
                end
            endcase
            if (wr && ins.rd != 5'd0) rf[ins.rd] = res;   // r0 stays zero.
            pc    = next_pc;
            steps = steps + 1;
        end
        if (!done) rule_broken("reference model never reached the done store");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus, memory model and watchdog

    initial begin
        rst_n = 1'b0;
        build_program();
        run_reference();
        prog_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

    // Each transfer gets 0 to 2 wait states before its one-cycle ack.
    always @(negedge clk) begin
        if (!rst_n || wb_ack) begin
            wb_ack  = 1'b0;
            in_xfer = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!in_xfer) begin
                in_xfer   = 1'b1;
                wait_left = {$random(seed)} % 3;
            end
            if (wait_left == 0) begin
                wb_ack = 1'b1;
                if (wb_we) mem[wb_adr] = wb_dat_w;
                else       wb_dat_r = read_word(wb_adr);
            end else begin
                wait_left--;
            end
        end
    end

    initial begin : watchdog
        int limit_ns;
        wait (prog_ready);
        limit_ns = prog.size() * 40 * 3 * CLK_PERIOD;
        #(limit_ns);
        rule_broken("timeout, the store to the done address never arrived");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus checks

    task automatic check_store();
        logic [31:0] want_adr;
        logic [31:0] want_dat;
        assert (exp_addr.size() != 0)
            else rule_broken("a store reached the bus after the expected list ran out");
        want_adr = exp_addr.pop_front();
        want_dat = exp_data.pop_front();
        assert (wb_adr == want_adr) else value_mismatch("wb_adr", want_adr, wb_adr);
        assert (wb_dat_w == want_dat) else value_mismatch("wb_dat_w", want_dat, wb_dat_w);
        stores_seen = stores_seen + 1;
        if (want_adr == DONE_ADDR) begin
            if (exp_addr.size() == 0) begin
                $display("%0d stores matched the reference model", stores_seen);
                $display("=== PASS ===");
                $finish;
            end else begin
                rule_broken("the done store arrived while stores were still expected");
            end
        end
    endtask

    always @(posedge clk) begin
        rst_q     <= rst_n;
        pending_q <= rst_n && wb_cyc && !wb_ack;
        acked_q   <= rst_n && wb_cyc && wb_ack;
        prev_adr  <= wb_adr;
        prev_we   <= wb_we;
        prev_dat  <= wb_dat_w;
        if (rst_n && !rst_q) begin
            assert (!wb_cyc && !wb_stb && !wb_we)
                else rule_broken("a bus cycle is open in the first cycle after reset");
        end
        if (rst_n) begin
            assert (wb_cyc == wb_stb) else value_mismatch("wb_stb", 32'(wb_cyc), 32'(wb_stb));
            if (wb_cyc) begin
                assert (wb_sel == '1) else value_mismatch("wb_sel", 32'hf, 32'(wb_sel));
                assert (wb_adr[1:0] == 2'b00) else rule_broken("unaligned address on the bus");
            end
            if (pending_q) begin             // Transfer still waiting for its ack.
                assert (wb_stb) else rule_broken("wb_stb dropped before wb_ack");
                assert (wb_adr == prev_adr) else value_mismatch("wb_adr", prev_adr, wb_adr);
                assert (wb_we == prev_we) else value_mismatch("wb_we", 32'(prev_we), 32'(wb_we));
                if (prev_we) begin
                    assert (wb_dat_w == prev_dat)
                        else value_mismatch("wb_dat_w", prev_dat, wb_dat_w);
                end
            end
            if (acked_q) begin
                assert (!wb_cyc) else rule_broken("no idle cycle after wb_ack");
            end
            if (wb_cyc && wb_ack && wb_we) check_store();
        end
    end

endmodule

//--- core_top.sv
`include "cpu_defs.svh"

module core_top import isa_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  u32_t              wb_dat_r,
    input  logic              wb_ack,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output u32_t              wb_adr,
    output u32_t              wb_dat_w,
    output logic [`NBYTE-1:0] wb_sel
);

    logic         fetch_req, fetch_done, mem_done;
    u32_t         fetch_pc, bus_rdata;
    logic         f_valid, fd_valid, de_valid;
    fd_payload_t  f_payload, fd_data;
    de_payload_t  d_payload, de_data;
    instr_class_t d_cls;
    alu_op_t      d_alu_op;
    reg_idx_t     d_rj, d_rkd, d_rd;
    u32_t         d_imm, rj_data, rkd_data;
    logic         d_reg_we, d_use_imm;
    logic         stall, mem_req, mem_we, redirect;
    u32_t         mem_addr, mem_wdata, redirect_pc;
    logic         rf_we;
    reg_idx_t     rf_rd;
    u32_t         rf_wdata;

    ////////////////////////////////////////////////////////////////////////////
    // F stage

    fetch_unit fetch_inst (
        .clk, .rst_n, .stall, .redirect, .redirect_pc, .fetch_done,
        .rdata (bus_rdata), .fetch_req, .fetch_pc, .f_valid, .f_payload
    );

    stage_reg #(.payload_t(fd_payload_t)) fd_reg_inst (
        .clk, .rst_n, .stall, .flush (redirect),
        .in_valid (f_valid), .in_data (f_payload), .out_valid (fd_valid), .out_data (fd_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // D stage

    decoder decoder_inst (
        .instr (fd_data.instr), .pc (fd_data.pc), .cls (d_cls), .alu_op (d_alu_op),
        .rj (d_rj), .rkd (d_rkd), .rd (d_rd), .imm (d_imm),
        .reg_we (d_reg_we), .use_imm (d_use_imm)
    );

    reg_file reg_file_inst (
        .clk, .rst_n, .rj (d_rj), .rkd (d_rkd),
        .we (rf_we), .rd (rf_rd), .rd_data (rf_wdata), .rj_data, .rkd_data
    );

    // Operand b is chosen here so E only sees one second operand for the ALU.
    assign d_payload = '{
        pc:      fd_data.pc,
        cls:     d_cls,
        alu_op:  d_alu_op,
        rd:      d_rd,
        we:      d_reg_we,
        imm:     d_use_imm ? d_imm : rkd_data,
        rj_val:  rj_data,
        rkd_val: rkd_data,
        br_off:  d_imm
    };

    stage_reg #(.payload_t(de_payload_t)) de_reg_inst (
        .clk, .rst_n, .stall, .flush (redirect),
        .in_valid (fd_valid), .in_data (d_payload), .out_valid (de_valid), .out_data (de_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // E stage and bus

    exec_unit exec_inst (
        .e_valid (de_valid), .e_data (de_data), .mem_done, .rdata (bus_rdata),
        .stall, .mem_req, .mem_we, .mem_addr, .mem_wdata, .redirect, .redirect_pc,
        .we (rf_we), .rd (rf_rd), .rd_data (rf_wdata)
    );

    wb_master wb_master_inst (
        .clk, .rst_n, .fetch_req, .fetch_pc, .mem_req, .mem_we, .mem_addr, .mem_wdata,
        .wb_dat_r, .wb_ack, .fetch_done, .mem_done, .rdata (bus_rdata),
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel
    );

endmodule

//--- wb_master.sv
`include "cpu_defs.svh"

module wb_master import isa_pkg::*, bus_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_req,
    input  u32_t              fetch_pc,
    input  logic              mem_req,
    input  logic              mem_we,
    input  u32_t              mem_addr,
    input  u32_t              mem_wdata,
    input  u32_t              wb_dat_r,
    input  logic              wb_ack,
    output logic              fetch_done,
    output logic              mem_done,
    output u32_t              rdata,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output u32_t              wb_adr,
    output u32_t              wb_dat_w,
    output logic [`NBYTE-1:0] wb_sel
);

    bus_state_t state;
    requester_t owner;
    u32_t       adr_q;
    u32_t       dat_q;
    logic       we_q;
    logic       busy;

    assign busy = (state == BUS_BUSY);

    ////////////////////////////////////////////////////////////////////////////
    // Request capture

    // Requests are only taken in the idle cycle that follows every ack.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= BUS_IDLE;
        end else if (busy) begin
            if (wb_ack) state <= BUS_IDLE;
        end else if (mem_req || fetch_req) begin
            state <= BUS_BUSY;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            if (mem_req) begin                  // Data goes before fetch.
                owner <= REQ_DATA;
                adr_q <= mem_addr;
                dat_q <= mem_wdata;
                we_q  <= mem_we;
            end else begin
                owner <= REQ_FETCH;
                adr_q <= fetch_pc;
                dat_q <= mem_wdata;
                we_q  <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus side

    assign wb_cyc   = busy;
    assign wb_stb   = busy;
    assign wb_we    = busy && we_q;
    assign wb_adr   = adr_q;
    assign wb_dat_w = dat_q;
    assign wb_sel   = '1;

    assign fetch_done = busy && wb_ack && (owner == REQ_FETCH);
    assign mem_done   = busy && wb_ack && (owner == REQ_DATA);
    assign rdata      = wb_dat_r;

endmodule

//--- fetch_unit.sv
`include "cpu_defs.svh"

module fetch_unit import isa_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        redirect,
    input  u32_t        redirect_pc,
    input  logic        fetch_done,
    input  u32_t        rdata,
    output logic        fetch_req,
    output u32_t        fetch_pc,
    output logic        f_valid,
    output fd_payload_t f_payload
);

    u32_t pc;
    u32_t held_word;
    logic held;                                 // Fetched word waits out a stall.
    logic drop;                                 // Fetch on the bus is for an old path.
    logic fresh;

    assign fresh     = fetch_done && !drop;
    assign f_valid   = held || fresh;
    assign fetch_req = !held && !drop;
    assign fetch_pc  = pc;

    assign f_payload.pc    = pc;
    assign f_payload.instr = held ? held_word : rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc   <= `RESET_PC;
            held <= 1'b0;
            drop <= 1'b0;
        end else if (redirect) begin
            pc   <= redirect_pc;
            held <= 1'b0;
            drop <= (fetch_req || drop) && !fetch_done;   // Its ack is still to come.
        end else begin
            if (fetch_done) drop <= 1'b0;
            if (f_valid && !stall) begin
                pc   <= pc + 32'd4;
                held <= 1'b0;
            end else if (fresh && stall) begin
                held <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fresh && stall) held_word <= rdata;
    end

endmodule

//--- stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // A flush wins over a stall.
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out_data <= in_data;
        end
    end

endmodule

//--- exec_unit.sv
`include "cpu_defs.svh"

module exec_unit import isa_pkg::*; (
    input  logic        e_valid,
    input  de_payload_t e_data,
    input  logic        mem_done,
    input  u32_t        rdata,
    output logic        stall,
    output logic        mem_req,
    output logic        mem_we,
    output u32_t        mem_addr,
    output u32_t        mem_wdata,
    output logic        redirect,
    output u32_t        redirect_pc,
    output logic        we,
    output reg_idx_t    rd,
    output u32_t        rd_data
);

    logic is_load;
    logic is_store;
    logic slt_lt;
    logic src_eq;
    logic taken;
    u32_t alu_res;

    assign is_load  = e_valid && (e_data.cls == CLS_LOAD);
    assign is_store = e_valid && (e_data.cls == CLS_STORE);

    ////////////////////////////////////////////////////////////////////////////
    // Memory access

    // The request stays up for as long as the instruction sits in E.
    assign mem_req   = (is_load || is_store) && !mem_done;
    assign stall     = mem_req;
    assign mem_we    = is_store;
    assign mem_addr  = e_data.rj_val + e_data.imm;
    assign mem_wdata = e_data.rkd_val;

    ////////////////////////////////////////////////////////////////////////////
    // ALU

    assign slt_lt = $signed(e_data.rj_val) < $signed(e_data.imm);

    always_comb begin
        case (e_data.alu_op)
            ALU_ADD:    alu_res = e_data.rj_val + e_data.imm;
            ALU_SUB:    alu_res = e_data.rj_val - e_data.imm;
            ALU_AND:    alu_res = e_data.rj_val & e_data.imm;
            ALU_OR:     alu_res = e_data.rj_val | e_data.imm;
            ALU_XOR:    alu_res = e_data.rj_val ^ e_data.imm;
            ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, slt_lt};
            ALU_PASS_B: alu_res = e_data.imm;
            default:    alu_res = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Branch

    assign src_eq = (e_data.rj_val == e_data.rkd_val);

    always_comb begin
        case (e_data.cls)
            CLS_BEQ:  taken = src_eq;
            CLS_BNE:  taken = !src_eq;
            CLS_JUMP: taken = 1'b1;
            default:  taken = 1'b0;
        endcase
    end

    assign redirect    = e_valid && taken;
    assign redirect_pc = e_data.pc + e_data.br_off;

    // Write back. A load only retires in its mem_done cycle.
    assign we      = e_valid && e_data.we && !stall;
    assign rd      = e_data.rd;
    assign rd_data = is_load ? rdata : alu_res;

endmodule

//--- decoder.sv
module decoder import isa_pkg::*; (
    input  u32_t         instr,
    input  u32_t         pc,
    output instr_class_t cls,
    output alu_op_t      alu_op,
    output reg_idx_t     rj,
    output reg_idx_t     rkd,
    output reg_idx_t     rd,
    output u32_t         imm,
    output logic         reg_we,
    output logic         use_imm
);

    u32_t si12;
    u32_t si20;
    u32_t offs16;
    u32_t offs26;
    logic rr_hit;

    assign rj = instr[9:5];
    assign rd = instr[4:0];

    assign si12   = {{20{instr[21]}}, instr[21:10]};
    assign si20   = {instr[24:5], 12'b0};
    assign offs16 = {{14{instr[25]}}, instr[25:10], 2'b00};
    assign offs26 = {{4{instr[9]}}, instr[9:0], instr[25:10], 2'b00};

    // Three register ALU group, opcode in bits 31 to 15.
    always_comb begin
        rr_hit = 1'b1;
        alu_op = ALU_ADD;
        case (instr[31:15])
            17'h00020: alu_op = ALU_ADD;
            17'h00022: alu_op = ALU_SUB;
            17'h00024: alu_op = ALU_SLT;
            17'h00029: alu_op = ALU_AND;
            17'h0002a: alu_op = ALU_OR;
            17'h0002b: alu_op = ALU_XOR;
            default: begin
                rr_hit = 1'b0;
                if (instr[31:25] == 7'b0001010) alu_op = ALU_PASS_B;
            end
        endcase
    end

    always_comb begin
        cls     = CLS_INVALID;
        rkd     = instr[14:10];
        imm     = si12;
        reg_we  = 1'b0;
        use_imm = 1'b0;
        // A word fetched from a misaligned PC is not executed.
        if (pc[1:0] == 2'b00) begin
            if (rr_hit) begin
                cls    = CLS_ALU;
                reg_we = 1'b1;
            end else if (instr[31:22] == 10'h00a) begin     // ADDI.W
                cls     = CLS_ALU;
                reg_we  = 1'b1;
                use_imm = 1'b1;
            end else if (instr[31:25] == 7'b0001010) begin  // LU12I.W
                cls     = CLS_ALU;
                imm     = si20;
                reg_we  = 1'b1;
                use_imm = 1'b1;
            end else if (instr[31:22] == 10'h0a2) begin     // LD.W
                cls     = CLS_LOAD;
                reg_we  = 1'b1;
                use_imm = 1'b1;
            end else if (instr[31:22] == 10'h0a6) begin     // ST.W
                cls     = CLS_STORE;
                rkd     = instr[4:0];
                use_imm = 1'b1;
            end else if (instr[31:26] == 6'b010110) begin
                cls = CLS_BEQ;
                rkd = instr[4:0];
                imm = offs16;
            end else if (instr[31:26] == 6'b010111) begin
                cls = CLS_BNE;
                rkd = instr[4:0];
                imm = offs16;
            end else if (instr[31:26] == 6'b010100) begin
                cls = CLS_JUMP;
                imm = offs26;
            end
        end
    end

endmodule

//--- reg_file.sv
`include "cpu_defs.svh"

module reg_file import isa_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rj,
    input  reg_idx_t rkd,
    input  logic     we,
    input  reg_idx_t rd,
    input  u32_t     rd_data,
    output u32_t     rj_data,
    output u32_t     rkd_data
);

    u32_t regs [`NREG];

    // A write in E lands on the same edge that D samples its operands,
    // so the write data is passed straight through to a matching read.
    always_comb begin
        if (we && (rj == rd) && (rj != '0)) rj_data = rd_data;
        else                                 rj_data = regs[rj];
    end

    always_comb begin
        if (we && (rkd == rd) && (rkd != '0)) rkd_data = rd_data;
        else                                   rkd_data = regs[rkd];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs[0] <= '0;                      // Only r0 has a defined value.
        end else if (we && (rd != '0)) begin
            regs[rd] <= rd_data;
        end
    end

endmodule

//--- bus_pkg.sv
package bus_pkg;

    // Owner of the transfer that is currently on the bus.
    typedef enum logic {
        REQ_FETCH,
        REQ_DATA
    } requester_t;

    typedef enum logic {
        BUS_IDLE,
        BUS_BUSY
    } bus_state_t;

endpackage

//--- isa_pkg.sv
`include "cpu_defs.svh"

package isa_pkg;

    typedef logic [$clog2(`NREG)-1:0] reg_idx_t;
    typedef logic [`XLEN-1:0]         u32_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B                              // LU12I.W just forwards its immediate.
    } alu_op_t;

    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_BEQ,
        CLS_BNE,
        CLS_JUMP,
        CLS_INVALID
    } instr_class_t;

    // F/D register contents.
    typedef struct packed {
        u32_t pc;
        u32_t instr;
    } fd_payload_t;

    // D/E register contents.
    typedef struct packed {
        u32_t         pc;
        instr_class_t cls;
        alu_op_t      alu_op;
        reg_idx_t     rd;
        logic         we;
        u32_t         imm;                      // ALU operand b, immediate or rk value.
        u32_t         rj_val;
        u32_t         rkd_val;                  // Store data and second branch operand.
        u32_t         br_off;
    } de_payload_t;

endpackage

//--- cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Core wide sizing constants.

// Width of a data word and of an address.
`define XLEN 32

// Number of general purpose registers, r0 included.
`define NREG 32

// Address of the first instruction fetched after reset.
`define RESET_PC 32'h1c00_0000

// Byte lanes per bus word.
`define NBYTE (`XLEN / 8)

`endif
